/* logic/fm_settings.svh */
`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// slot organisation of the core
`define FM_SLOTS 24
`define FM_CHANNELS 6
`define FM_OPS 4

// circulating word widths of op_params_t and ch_params_t
`define FM_OP_WIDTH 44
`define FM_CH_WIDTH 27

`endif

/* logic/fm_pkg.sv */
package fm_pkg;

	// kinds of host register writes
	typedef enum logic [3:0] {
		keyon,
		alg_fb,
		block_fhi,
		fnum_lo,
		pan_pms,
		dt_mul,
		tl,
		ks_ar,
		am_d1r,
		d2r,
		d1l_rr,
		ssg
	} reg_kind_e;

	typedef enum logic [1:0] {
		idle,
		update,
		drain,
		ack_wait
	} host_state_e;

	typedef struct packed {
		reg_kind_e  kind;
		logic [2:0] ch;
		logic [1:0] op;
		logic [7:0] data;
	} host_wr_t;

	// per-operator parameters, one word per slot
	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       amen;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
		logic       ssg_en;
		logic [2:0] ssg_eg;
	} op_params_t;

	// per-channel parameters
	typedef struct packed {
		logic [2:0]  block;
		logic [10:0] fnum;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [1:0]  rl;
		logic [1:0]  ams;
		logic [2:0]  pms;
	} ch_params_t;

	typedef struct packed {
		logic s1;
		logic s2;
		logic s3;
		logic s4;
	} stage_t;

	typedef struct packed {
		logic use_prevprev1;
		logic use_internal_x;
		logic use_internal_y;
		logic use_prev2;
		logic use_prev1;
	} route_t;

endpackage

/* logic/fm_shift_mem.sv */
module fm_shift_mem #(
	parameter int width = 8,
	parameter int stages = 2
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout
);

	logic [width-1:0] chain [stages];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < stages; i++) begin
				chain[i] <= '0;
			end
		end else begin
			chain[0] <= din;
			for (int i = 1; i < stages; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// oldest entry comes back around
	assign dout = chain[stages-1];

endmodule

/* logic/fm_stage_sync.sv */
module fm_stage_sync (
	input  logic           clk,
	input  logic           rst,
	input  logic [4:0]     next,
	output fm_pkg::stage_t stage
);

	fm_pkg::stage_t group;

	// slot groups in visiting order S1, S3, S2, S4
	always_comb begin
		group = '0;
		if (next < 5'd6) begin
			group.s1 = 1'b1;
		end else if (next < 5'd12) begin
			group.s3 = 1'b1;
		end else if (next < 5'd18) begin
			group.s2 = 1'b1;
		end else begin
			group.s4 = 1'b1;
		end
	end

	// registered so the marker lines up with cur
	always_ff @(posedge clk) begin
		if (rst) begin
			stage <= '0;
		end else begin
			stage <= group;
		end
	end

endmodule

/* logic/fm_key_ctl.sv */
`include "fm_settings.svh"

module fm_key_ctl (
	input  logic       clk,
	input  logic       rst,
	input  logic [4:0] next,
	input  logic       keyon_upd,
	input  logic [3:0] op_mask,
	input  logic [2:0] key_ch,
	input  logic       csm,
	input  logic       overflow_a,
	output logic       key_on,
	output logic       key_off
);

	logic [4:0] slot;
	logic [1:0] slot_op;
	logic [2:0] slot_ch;
	logic [4:0] csm_left;
	logic       csm_on;
	logic       kreg_new;
	logic       keff_new;
	// bit 1 is the written key, bit 0 the effective key
	logic [1:0] kmem_in;
	logic [1:0] kmem_out;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= 5'd0;
		end else begin
			slot <= next;
		end
	end

	// split the slot into operator group and channel
	always_comb begin
		slot_op = 2'd0;
		slot_ch = 3'(slot);
		for (int i = 1; i < `FM_OPS; i++) begin
			if (slot >= 5'(i * `FM_CHANNELS)) begin
				slot_op = 2'(i);
				slot_ch = 3'(slot - 5'(i * `FM_CHANNELS));
			end
		end
	end

	// csm window lasts one full revolution
	always_ff @(posedge clk) begin
		if (rst) begin
			csm_left <= 5'd0;
		end else if (csm && overflow_a) begin
			csm_left <= 5'(`FM_SLOTS);
		end else if (csm_on) begin
			csm_left <= csm_left - 5'd1;
		end
	end

	assign csm_on = csm_left != 5'd0;

	// op_mask bit i belongs to op code i
	assign kreg_new = (keyon_upd && slot_ch == key_ch) ? op_mask[slot_op] : kmem_out[1];
	assign keff_new = kreg_new | (csm_on && slot_ch == 3'd2);
	assign kmem_in = {kreg_new, keff_new};

	fm_shift_mem #(
		.width (2),
		.stages(`FM_SLOTS)
	) u_kmem (
		.clk (clk),
		.rst (rst),
		.din (kmem_in),
		.dout(kmem_out)
	);

	// edges of the effective key, seen at stage II
	always_ff @(posedge clk) begin
		if (rst) begin
			key_on <= 1'b0;
			key_off <= 1'b0;
		end else begin
			key_on <= keff_new & ~kmem_out[0];
			key_off <= ~keff_new & kmem_out[0];
		end
	end

endmodule

/* logic/fm_alg_route.sv */
module fm_alg_route (
	input  logic [2:0]     alg,
	input  fm_pkg::stage_t stage,
	output fm_pkg::route_t route
);

	// prev1 and prev2 are the outputs one and two operators back,
	// prevprev1 reuses the modulator of the previous operator,
	// internal_x holds S1 and internal_y holds S3 for the last sum
	always_comb begin
		route = '0;
		if (stage.s3) begin
			route.use_prev1 = alg == 3'd0 || alg == 3'd3 || alg == 3'd4 ||
				alg == 3'd5 || alg == 3'd6;
		end
		if (stage.s2) begin
			route.use_prev1 = alg == 3'd0 || alg == 3'd1 || alg == 3'd2;
			route.use_prev2 = alg == 3'd1;
			route.use_prevprev1 = alg == 3'd5;
		end
		if (stage.s4) begin
			route.use_prev1 = alg == 3'd0 || alg == 3'd1 || alg == 3'd2 ||
				alg == 3'd3 || alg == 3'd4;
			route.use_internal_x = alg == 3'd2;
			route.use_internal_y = alg == 3'd3;
			route.use_prevprev1 = alg == 3'd5;
		end
	end

endmodule

/* logic/fm_reg_file.sv */
`include "fm_settings.svh"

module fm_reg_file (
	input  logic               clk,
	input  logic               rst,
	input  fm_pkg::host_wr_t   upd,
	input  logic               upd_valid,
	input  logic               csm,
	input  logic               overflow_a,
	output logic               busy,
	output logic               zero,
	output fm_pkg::stage_t     stage,
	output fm_pkg::route_t     route,
	output fm_pkg::op_params_t op_out,
	output fm_pkg::ch_params_t ch_out,
	output logic               key_on,
	output logic               key_off
);

	logic [4:0] cur;
	logic [4:0] next;
	logic [4:0] cnt;
	logic [4:0] prev_slot;
	logic [4:0] op_slot;
	logic       last;
	logic       ch_ok;
	logic       op_hit;
	logic       ch_hit;
	logic       keyon_upd;
	fm_pkg::op_params_t op_cur;
	fm_pkg::op_params_t op_new;
	fm_pkg::ch_params_t ch_cur;
	fm_pkg::ch_params_t ch_new;

	assign next = (cur == 5'(`FM_SLOTS - 1)) ? 5'd0 : cur + 5'd1;
	assign prev_slot = (cur == 5'd0) ? 5'(`FM_SLOTS - 1) : cur - 5'd1;

	// busy covers one revolution from the first valid cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			cur <= 5'd0;
			cnt <= 5'd0;
			zero <= 1'b0;
			last <= 1'b0;
			busy <= 1'b0;
		end else begin
			cur <= next;
			zero <= next == 5'd0;
			last <= upd_valid;
			if (upd_valid && !last) begin
				cnt <= cur;
				busy <= 1'b1;
			end else if (cnt == cur) begin
				busy <= 1'b0;
			end
		end
	end

	// slot is op times six plus channel
	assign op_slot = 5'(upd.op) * 5'(`FM_CHANNELS) + 5'(upd.ch);
	assign ch_ok = upd.ch < 3'(`FM_CHANNELS);

	// operator word for slot k is at the memory output when cur is k+1
	assign op_hit = upd_valid && ch_ok && prev_slot == op_slot;
	assign ch_hit = upd_valid && ch_ok && cur == 5'(upd.ch);
	assign keyon_upd = upd_valid && upd.kind == fm_pkg::keyon;

	always_comb begin
		op_new = op_cur;
		if (op_hit) begin
			case (upd.kind)
				fm_pkg::dt_mul: begin
					op_new.dt1 = upd.data[6:4];
					op_new.mul = upd.data[3:0];
				end
				fm_pkg::tl: op_new.tl = upd.data[6:0];
				fm_pkg::ks_ar: begin
					op_new.ks = upd.data[7:6];
					op_new.ar = upd.data[4:0];
				end
				fm_pkg::am_d1r: begin
					op_new.amen = upd.data[7];
					op_new.d1r = upd.data[4:0];
				end
				fm_pkg::d2r: op_new.d2r = upd.data[4:0];
				fm_pkg::d1l_rr: begin
					op_new.d1l = upd.data[7:4];
					op_new.rr = upd.data[3:0];
				end
				fm_pkg::ssg: begin
					op_new.ssg_en = upd.data[3];
					op_new.ssg_eg = upd.data[2:0];
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		ch_new = ch_cur;
		if (ch_hit) begin
			case (upd.kind)
				fm_pkg::alg_fb: begin
					ch_new.fb = upd.data[5:3];
					ch_new.alg = upd.data[2:0];
				end
				fm_pkg::block_fhi: begin
					ch_new.block = upd.data[5:3];
					ch_new.fnum[10:8] = upd.data[2:0];
				end
				fm_pkg::fnum_lo: ch_new.fnum[7:0] = upd.data;
				fm_pkg::pan_pms: begin
					ch_new.rl = upd.data[7:6];
					ch_new.ams = upd.data[5:4];
					ch_new.pms = upd.data[2:0];
				end
				default: ;
			endcase
		end
	end

	fm_shift_mem #(
		.width (`FM_OP_WIDTH),
		.stages(`FM_SLOTS)
	) u_op_mem (
		.clk (clk),
		.rst (rst),
		.din (op_new),
		.dout(op_cur)
	);

	// six stages, so each channel passes four times per revolution
	fm_shift_mem #(
		.width (`FM_CH_WIDTH),
		.stages(`FM_CHANNELS)
	) u_ch_mem (
		.clk (clk),
		.rst (rst),
		.din (ch_new),
		.dout(ch_cur)
	);

	assign op_out = op_cur;
	assign ch_out = ch_cur;

	fm_key_ctl u_key_ctl (
		.clk       (clk),
		.rst       (rst),
		.next      (next),
		.keyon_upd (keyon_upd),
		.op_mask   (upd.data[7:4]),
		.key_ch    (upd.data[2:0]),
		.csm       (csm),
		.overflow_a(overflow_a),
		.key_on    (key_on),
		.key_off   (key_off)
	);

	fm_stage_sync u_stage_sync (
		.clk  (clk),
		.rst  (rst),
		.next (next),
		.stage(stage)
	);

	fm_alg_route u_alg_route (
		.alg  (ch_cur.alg),
		.stage(stage),
		.route(route)
	);

endmodule

/* logic/fm_host_port.sv */
module fm_host_port (
	input  logic             clk,
	input  logic             rst,
	input  logic             req,
	input  fm_pkg::host_wr_t wr,
	input  logic             busy,
	output logic             ack,
	output fm_pkg::host_wr_t upd,
	output logic             upd_valid
);

	fm_pkg::host_state_e state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fm_pkg::idle;
		end else begin
			case (state)
				fm_pkg::idle: begin
					if (req) begin
						state <= fm_pkg::update;
					end
				end
				// wait for the register file to pick it up
				fm_pkg::update: begin
					if (busy) begin
						state <= fm_pkg::drain;
					end
				end
				// one full revolution
				fm_pkg::drain: begin
					if (!busy) begin
						state <= fm_pkg::ack_wait;
					end
				end
				fm_pkg::ack_wait: begin
					if (!req) begin
						state <= fm_pkg::idle;
					end
				end
				default: state <= fm_pkg::idle;
			endcase
		end
	end

	// host holds wr stable while req is high
	always_ff @(posedge clk) begin
		if (state == fm_pkg::idle && req) begin
			upd <= wr;
		end
	end

	assign upd_valid = state == fm_pkg::update || state == fm_pkg::drain;
	assign ack = state == fm_pkg::ack_wait;

endmodule

/* logic/fm_regs_top.sv */
module fm_regs_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	input  fm_pkg::host_wr_t   wr,
	input  logic               csm,
	input  logic               overflow_a,
	output logic               ack,
	output logic               zero,
	output fm_pkg::stage_t     stage,
	output fm_pkg::route_t     route,
	output fm_pkg::op_params_t op_out,
	output fm_pkg::ch_params_t ch_out,
	output logic               key_on,
	output logic               key_off
);

	fm_pkg::host_wr_t upd;
	logic             upd_valid;
	logic             busy;

	fm_host_port u_host_port (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.wr       (wr),
		.busy     (busy),
		.ack      (ack),
		.upd      (upd),
		.upd_valid(upd_valid)
	);

	fm_reg_file u_reg_file (
		.clk       (clk),
		.rst       (rst),
		.upd       (upd),
		.upd_valid (upd_valid),
		.csm       (csm),
		.overflow_a(overflow_a),
		.busy      (busy),
		.zero      (zero),
		.stage     (stage),
		.route     (route),
		.op_out    (op_out),
		.ch_out    (ch_out),
		.key_on    (key_on),
		.key_off   (key_off)
	);

endmodule

/* bench/fm_host_tasks.svh */
`ifndef FM_HOST_TASKS_SVH
`define FM_HOST_TASKS_SVH

// one register write through the four-phase port, starting on a falling edge
task automatic host_write(input fm_pkg::reg_kind_e kind, input logic [2:0] ch,
	input logic [1:0] op, input logic [7:0] data);
	int cycles;
	int slot;
	cycles = 0;
	slot = op * `FM_CHANNELS + ch;
	writing = 1'b1;
	wr.kind = kind;
	wr.ch = ch;
	wr.op = op;
	wr.data = data;
	req = 1'b1;
	// req is sampled on the rising edge before this
	@(negedge clk);
	while (!ack) begin
		@(negedge clk);
		cycles++;
		if (cycles > 40) begin
			report_failure("ack did not rise after a write request");
		end
	end
	assert (cycles == 26) else report_mismatch("ack latency", 64'd26, 64'(cycles));
	op_shadow[slot] = merge_op(op_shadow[slot], kind, data);
	ch_shadow[ch] = merge_ch(ch_shadow[ch], kind, data);
	req = 1'b0;
	cycles = 0;
	while (ack) begin
		@(negedge clk);
		cycles++;
		if (cycles > 4) begin
			report_failure("ack did not fall after req was dropped");
		end
	end
	writing = 1'b0;
endtask

// returns on the falling edge of the next cycle with zero high
task automatic wait_zero();
	int cycles;
	cycles = 0;
	@(negedge clk);
	while (!zero) begin
		@(negedge clk);
		cycles++;
		if (cycles > `FM_SLOTS + 2) begin
			report_failure("zero did not pulse within one revolution");
		end
	end
endtask

// forget earlier key events and set the ones to come
task automatic arm_keys(input logic [`FM_SLOTS-1:0] on_mask,
	input logic [`FM_SLOTS-1:0] off_mask);
	seen_clear = 1'b1;
	@(negedge clk);
	seen_clear = 1'b0;
	on_expect = on_mask;
	off_expect = off_mask;
endtask

task automatic wait_keys();
	int cycles;
	cycles = 0;
	while (on_seen != on_expect || off_seen != off_expect) begin
		@(negedge clk);
		cycles++;
		if (cycles > 3 * `FM_SLOTS) begin
			report_failure("expected key events did not all arrive");
		end
	end
endtask

`endif

/* bench/fm_regs_tb.sv */
`include "fm_settings.svh"

module fm_regs_tb;

	logic               clk;
	logic               rst;
	logic               req;
	fm_pkg::host_wr_t   wr;
	logic               csm;
	logic               overflow_a;
	logic               ack;
	logic               zero;
	fm_pkg::stage_t     stage;
	fm_pkg::route_t     route;
	fm_pkg::op_params_t op_out;
	fm_pkg::ch_params_t ch_out;
	logic               key_on;
	logic               key_off;

	// reference slot model, advanced on the rising edge
	logic [4:0]           slot_m;
	logic [4:0]           prev_m;
	logic                 synced;
	logic                 writing;
	logic                 checking;
	fm_pkg::op_params_t   op_shadow [`FM_SLOTS];
	fm_pkg::ch_params_t   ch_shadow [`FM_CHANNELS];
	fm_pkg::op_params_t   exp_op;
	fm_pkg::ch_params_t   exp_ch;
	logic [`FM_SLOTS-1:0] on_expect;
	logic [`FM_SLOTS-1:0] off_expect;
	logic [`FM_SLOTS-1:0] on_seen;
	logic [`FM_SLOTS-1:0] off_seen;
	logic                 seen_clear;

	fm_regs_top DUT (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.wr        (wr),
		.csm       (csm),
		.overflow_a(overflow_a),
		.ack       (ack),
		.zero      (zero),
		.stage     (stage),
		.route     (route),
		.op_out    (op_out),
		.ch_out    (ch_out),
		.key_on    (key_on),
		.key_off   (key_off)
	);

	always #50 begin
		clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("mismatch %s expected %0h actual %0h", name, expected, actual);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("error: %s", what);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	// operator groups come in the order S1, S3, S2, S4
	function automatic fm_pkg::stage_t group_of(input logic [4:0] s);
		fm_pkg::stage_t g;
		g = '0;
		case (s / 5'(`FM_CHANNELS))
			5'd0: g.s1 = 1'b1;
			5'd1: g.s3 = 1'b1;
			5'd2: g.s2 = 1'b1;
			default: g.s4 = 1'b1;
		endcase
		return g;
	endfunction

	// algorithm 0 feeds every later operator from the one before, 7 routes nothing
	function automatic fm_pkg::route_t chain_route(input logic [2:0] alg,
		input fm_pkg::stage_t st);
		fm_pkg::route_t r;
		r = '0;
		if (alg == 3'd0 && (st.s3 || st.s2 || st.s4)) begin
			r.use_prev1 = 1'b1;
		end
		return r;
	endfunction

	function automatic fm_pkg::op_params_t merge_op(input fm_pkg::op_params_t w,
		input fm_pkg::reg_kind_e kind, input logic [7:0] d);
		fm_pkg::op_params_t r;
		r = w;
		case (kind)
			fm_pkg::dt_mul: {r.dt1, r.mul} = d[6:0];
			fm_pkg::tl: r.tl = d[6:0];
			fm_pkg::ks_ar: {r.ks, r.ar} = {d[7:6], d[4:0]};
			fm_pkg::am_d1r: {r.amen, r.d1r} = {d[7], d[4:0]};
			fm_pkg::d2r: r.d2r = d[4:0];
			fm_pkg::d1l_rr: {r.d1l, r.rr} = d;
			fm_pkg::ssg: {r.ssg_en, r.ssg_eg} = d[3:0];
			default: r = w;
		endcase
		return r;
	endfunction

	function automatic fm_pkg::ch_params_t merge_ch(input fm_pkg::ch_params_t w,
		input fm_pkg::reg_kind_e kind, input logic [7:0] d);
		fm_pkg::ch_params_t r;
		r = w;
		case (kind)
			fm_pkg::alg_fb: {r.fb, r.alg} = d[5:0];
			fm_pkg::block_fhi: {r.block, r.fnum[10:8]} = d[5:0];
			fm_pkg::fnum_lo: r.fnum[7:0] = d;
			fm_pkg::pan_pms: {r.rl, r.ams, r.pms} = {d[7:4], d[2:0]};
			default: r = w;
		endcase
		return r;
	endfunction

	function automatic logic [`FM_SLOTS-1:0] key_slots(input logic [2:0] ch,
		input logic [3:0] mask);
		logic [`FM_SLOTS-1:0] m;
		m = '0;
		for (int i = 0; i < `FM_OPS; i++) begin
			if (mask[i]) begin
				m[i * `FM_CHANNELS + ch] = 1'b1;
			end
		end
		return m;
	endfunction

	`include "fm_host_tasks.svh"

	// resync on zero, then count slots on our own
	always @(posedge clk) begin
		checking <= writing;
		if (rst) begin
			synced <= 1'b0;
			slot_m <= 5'd0;
		end else if (zero) begin
			synced <= 1'b1;
			slot_m <= 5'd1;
		end else begin
			slot_m <= (slot_m == 5'(`FM_SLOTS - 1)) ? 5'd0 : slot_m + 5'd1;
		end
	end

	// key events belong to the slot before the current one
	always @(posedge clk) begin
		if (seen_clear) begin
			on_seen <= '0;
			off_seen <= '0;
		end else if (synced) begin
			if (key_on) begin
				on_seen[prev_m] <= 1'b1;
			end
			if (key_off) begin
				off_seen[prev_m] <= 1'b1;
			end
		end
	end

	assign prev_m = (slot_m == 5'd0) ? 5'(`FM_SLOTS - 1) : slot_m - 5'd1;
	assign exp_op = op_shadow[prev_m];
	assign exp_ch = ch_shadow[slot_m % 5'(`FM_CHANNELS)];

	// outputs settle after the rising edge, so look at them on the falling one
	assert property (@(negedge clk) synced |-> zero == (slot_m == 5'd0))
		else report_mismatch($sformatf("zero slot %0d", slot_m), slot_m == 5'd0, zero);
	assert property (@(negedge clk) synced |-> stage == group_of(slot_m))
		else report_mismatch($sformatf("stage slot %0d", slot_m), group_of(slot_m), stage);
	assert property (@(negedge clk) synced && !checking |-> !ack)
		else report_mismatch("ack while idle", 64'd0, ack);
	assert property (@(negedge clk) synced && !checking |-> op_out == exp_op)
		else report_mismatch($sformatf("op_out slot %0d", prev_m), exp_op, op_out);
	assert property (@(negedge clk)
		synced && !checking && slot_m < 5'(`FM_CHANNELS) |-> ch_out == exp_ch)
		else report_mismatch($sformatf("ch_out channel %0d", slot_m), exp_ch, ch_out);
	assert property (@(negedge clk) synced && !checking &&
		(exp_ch.alg == 3'd0 || exp_ch.alg == 3'd7) |->
		route == chain_route(exp_ch.alg, group_of(slot_m)))
		else report_mismatch($sformatf("route slot %0d", slot_m),
			chain_route(exp_ch.alg, group_of(slot_m)), route);
	assert property (@(negedge clk)
		synced && key_on |-> on_expect[prev_m] && !on_seen[prev_m])
		else report_mismatch($sformatf("key_on slot %0d", prev_m), 64'd0, key_on);
	assert property (@(negedge clk)
		synced && key_off |-> off_expect[prev_m] && !off_seen[prev_m])
		else report_mismatch($sformatf("key_off slot %0d", prev_m), 64'd0, key_off);

	initial begin
		int unsigned seed_val;
		fm_pkg::reg_kind_e kind;
		logic [2:0] ch;
		logic [3:0] mask;
		seed_val = $urandom(4243);
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		wr = '0;
		csm = 1'b0;
		overflow_a = 1'b0;
		writing = 1'b0;
		seen_clear = 1'b1;
		on_expect = '0;
		off_expect = '0;
		for (int i = 0; i < `FM_SLOTS; i++) begin
			op_shadow[i] = '0;
		end
		for (int i = 0; i < `FM_CHANNELS; i++) begin
			ch_shadow[i] = '0;
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;
		seen_clear = 1'b0;

		// idle revolutions for zero, stage and quiet outputs
		repeat (3) wait_zero();

		// random operator fields
		for (int n = 0; n < 12; n++) begin
			kind = fm_pkg::reg_kind_e'(4'(5 + $urandom % 7));
			host_write(kind, 3'($urandom % 6), 2'($urandom % 4), 8'($urandom));
			wait_zero();
			wait_zero();
		end

		// even channels get the serial chain, odd ones the parallel algorithm
		for (int c = 0; c < `FM_CHANNELS; c++) begin
			host_write(fm_pkg::alg_fb, 3'(c), 2'd0,
				{2'b00, 3'($urandom % 8), (c % 2 == 0) ? 3'd0 : 3'd7});
		end
		for (int n = 0; n < 6; n++) begin
			kind = fm_pkg::reg_kind_e'(4'(2 + $urandom % 3));
			host_write(kind, 3'($urandom % 6), 2'd0, 8'($urandom));
		end
		wait_zero();
		wait_zero();

		// key on, then key off for the same operators
		ch = 3'($urandom % 6);
		mask = 4'(1 + $urandom % 15);
		arm_keys(key_slots(ch, mask), '0);
		host_write(fm_pkg::keyon, 3'd0, 2'd0, {mask, 1'b0, ch});
		wait_keys();
		arm_keys('0, key_slots(ch, mask));
		host_write(fm_pkg::keyon, 3'd0, 2'd0, {4'd0, 1'b0, ch});
		wait_keys();

		// timer A overflow in CSM mode keys channel 2 for one revolution
		arm_keys(key_slots(3'd2, 4'hf), key_slots(3'd2, 4'hf));
		csm = 1'b1;
		overflow_a = 1'b1;
		@(negedge clk);
		overflow_a = 1'b0;
		wait_keys();
		csm = 1'b0;
		wait_zero();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* sim.f */
+incdir+logic
+incdir+bench
logic/fm_pkg.sv
logic/fm_shift_mem.sv
logic/fm_stage_sync.sv
logic/fm_key_ctl.sv
logic/fm_alg_route.sv
logic/fm_reg_file.sv
logic/fm_host_port.sv
logic/fm_regs_top.sv
bench/fm_regs_tb.sv
